//--- common/afu_pkg.sv
package afu_pkg;

	localparam int ADDR_W          = 32;
	localparam int NUM_TAGS        = 8;
	localparam int TAG_W           = 3;
	localparam int CREDIT_W        = 4;
	localparam int CMD_QUEUE_DEPTH = 4;
	localparam int RSP_QUEUE_DEPTH = 4;

	typedef enum logic {
		CLASS_READ  = 1'b0,
		CLASS_WRITE = 1'b1
	} cmd_class_t;

	// Host response codes, returned to the requester as they arrive
	typedef enum logic [1:0] {
		RSP_DONE   = 2'd0,
		RSP_FAILED = 2'd1,
		RSP_PAGED  = 2'd2
	} rsp_code_t;

	typedef struct packed {
		cmd_class_t        cmd_class;
		logic [ADDR_W-1:0] addr;
	} cmd_line_t;

	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		rsp_code_t         code;
		logic [ADDR_W-1:0] addr;
	} rsp_line_t;

endpackage

//--- common/issue_if.sv
`timescale 1ns/1ps

interface issue_if import afu_pkg::*; ();

	// Issue strobe with the command being issued
	logic              issue;
	cmd_class_t        issue_class;
	logic [ADDR_W-1:0] issue_addr;

	// Lowest free tag and host room
	logic              tag_avail;
	logic [TAG_W-1:0]  free_tag;
	logic              credit_avail;

	modport fsm (
		output issue, issue_class, issue_addr,
		input  tag_avail, free_tag, credit_avail
	);

	modport tags (input issue, issue_class, issue_addr, output tag_avail, free_tag);

	modport credits (input issue, output credit_avail);

endinterface

//--- common/rsp_if.sv
`timescale 1ns/1ps

interface rsp_if import afu_pkg::*; ();

	// One-cycle strobe, no back-pressure
	logic              rsp_valid;
	cmd_class_t        rsp_class;
	logic [TAG_W-1:0]  rsp_tag;
	rsp_code_t         rsp_code;
	logic [ADDR_W-1:0] rsp_addr;

	modport tags (
		output rsp_valid, rsp_class, rsp_tag, rsp_code, rsp_addr
	);

	modport router (
		input  rsp_valid, rsp_class, rsp_tag, rsp_code, rsp_addr
	);

endinterface

//--- logic/cmd_intake.sv
`timescale 1ns/1ps

module cmd_intake import afu_pkg::*; #(
	parameter cmd_class_t CMD_CLASS = CLASS_READ
) (
	input  logic              clock,
	input  logic              rstn,
	input  logic              req,
	output logic              ack,
	input  logic [ADDR_W-1:0] addr,
	input  logic              full,
	output logic              push,
	output cmd_line_t         push_line
);

	// A new command is taken only while ack is still low
	assign push = req && !ack && !full;

	assign push_line.cmd_class = CMD_CLASS;
	assign push_line.addr      = addr;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ack <= 1'b0;
		end else if (push) begin
			ack <= 1'b1;
		end else if (!req) begin
			ack <= 1'b0;
		end
	end

	// Source holds req and its address until ack
	assert property (@(posedge clock) disable iff (!rstn)
		req && !ack |=> req && $stable(addr));

endmodule

//--- logic/cmd_queue.sv
`timescale 1ns/1ps

module cmd_queue import afu_pkg::*; #(
	parameter type PAYLOAD_T = cmd_line_t,
	parameter int  DEPTH     = CMD_QUEUE_DEPTH
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  PAYLOAD_T push_data,
	input  logic     pop,
	output PAYLOAD_T pop_data,
	output logic     full,
	output logic     empty
);

	PAYLOAD_T                   mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic                       do_push;
	logic                       do_pop;

	assign full    = (count == DEPTH);
	assign empty   = (count == 0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Head entry is visible before the pop
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == DEPTH-1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == DEPTH-1) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty);
	assert property (@(posedge clock) disable iff (!rstn) push |-> !full);

endmodule

//--- issue/issue_fsm.sv
`timescale 1ns/1ps

module issue_fsm import afu_pkg::*; (
	input  logic              clock,
	input  logic              rstn,
	input  logic              enabled,
	input  logic              read_empty,
	input  logic              write_empty,
	input  cmd_line_t         read_line,
	input  cmd_line_t         write_line,
	output logic              read_pop,
	output logic              write_pop,
	issue_if.fsm              iss,
	output logic              host_cmd_valid,
	output cmd_class_t        host_cmd_class,
	output logic [TAG_W-1:0]  host_cmd_tag,
	output logic [ADDR_W-1:0] host_cmd_addr
);

	typedef enum logic [1:0] {
		IDLE,
		SELECT,
		ISSUE
	} state_t;

	state_t     state;
	cmd_class_t sel;
	cmd_class_t last;
	cmd_line_t  line;
	logic       ready;
	logic       go;

	// Host room, a free tag and the enable must all hold
	assign ready = enabled && iss.credit_avail && iss.tag_avail;
	assign go    = (state == ISSUE) && ready;

	assign line = (sel == CLASS_WRITE) ? write_line : read_line;

	assign iss.issue       = go;
	assign iss.issue_class = line.cmd_class;
	assign iss.issue_addr  = line.addr;

	assign read_pop  = go && (sel == CLASS_READ);
	assign write_pop = go && (sel == CLASS_WRITE);

	//////////////////////////////////////////////////
	// Round-robin state machine
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= IDLE;
			sel   <= CLASS_READ;
			// Read gets the first turn
			last  <= CLASS_WRITE;
		end else begin
			case (state)
				IDLE: begin
					if (ready && !(read_empty && write_empty)) begin
						state <= SELECT;
					end
				end
				SELECT: begin
					if (!read_empty && !write_empty) begin
						sel <= (last == CLASS_READ) ? CLASS_WRITE : CLASS_READ;
					end else if (!write_empty) begin
						sel <= CLASS_WRITE;
					end else begin
						sel <= CLASS_READ;
					end
					state <= ISSUE;
				end
				ISSUE: begin
					if (go) begin
						last <= sel;
					end
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Host command port
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			host_cmd_valid <= 1'b0;
		end else begin
			host_cmd_valid <= go;
		end
	end

	always_ff @(posedge clock) begin
		if (go) begin
			host_cmd_class <= line.cmd_class;
			host_cmd_tag   <= iss.free_tag;
			host_cmd_addr  <= line.addr;
		end
	end

endmodule

//--- issue/credit_counter.sv
`timescale 1ns/1ps

module credit_counter import afu_pkg::*; (
	input  logic                clock,
	input  logic                rstn,
	input  logic                enabled,
	input  logic [CREDIT_W-1:0] room,
	input  logic                rsp_valid,
	issue_if.credits            cred
);

	logic [CREDIT_W-1:0] count;

	assign cred.credit_avail = (count != '0);

	// Follows room until enabled, then tracks issues and responses
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			count <= '0;
		end else if (!enabled) begin
			count <= room;
		end else if (cred.issue && !rsp_valid) begin
			count <= count - 1'b1;
		end else if (rsp_valid && !cred.issue) begin
			count <= count + 1'b1;
		end
	end

	// An issue never spends a credit that is not there
	assert property (@(posedge clock) disable iff (!rstn)
		cred.issue |-> (count != '0));

endmodule

//--- logic/tag_table.sv
`timescale 1ns/1ps

module tag_table import afu_pkg::*; (
	input  logic             clock,
	input  logic             rstn,
	issue_if.tags            iss,
	input  logic             host_rsp_valid,
	input  logic [TAG_W-1:0] host_rsp_tag,
	input  rsp_code_t        host_rsp_code,
	rsp_if.tags              rsp
);

	logic [NUM_TAGS-1:0] busy;
	cmd_class_t          tag_class [NUM_TAGS];
	logic [ADDR_W-1:0]   tag_addr  [NUM_TAGS];

	// Lowest free tag wins
	always_comb begin
		iss.free_tag = '0;
		for (int i = NUM_TAGS-1; i >= 0; i--) begin
			if (!busy[i]) begin
				iss.free_tag = TAG_W'(i);
			end
		end
	end

	assign iss.tag_avail = !(&busy);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy          <= '0;
			rsp.rsp_valid <= 1'b0;
		end else begin
			if (iss.issue) begin
				busy[iss.free_tag] <= 1'b1;
			end
			if (host_rsp_valid) begin
				busy[host_rsp_tag] <= 1'b0;
			end
			rsp.rsp_valid <= host_rsp_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (iss.issue) begin
			tag_class[iss.free_tag] <= iss.issue_class;
			tag_addr[iss.free_tag]  <= iss.issue_addr;
		end
		// Resolve the tag back to its class and address
		if (host_rsp_valid) begin
			rsp.rsp_class <= tag_class[host_rsp_tag];
			rsp.rsp_tag   <= host_rsp_tag;
			rsp.rsp_code  <= host_rsp_code;
			rsp.rsp_addr  <= tag_addr[host_rsp_tag];
		end
	end

	// The host only answers tags that were issued
	assert property (@(posedge clock) disable iff (!rstn)
		host_rsp_valid |-> busy[host_rsp_tag]);

endmodule

//--- logic/response_router.sv
`timescale 1ns/1ps

module response_router import afu_pkg::*; (
	input  logic      clock,
	input  logic      rstn,
	rsp_if.router     rsp,
	output logic      read_rsp_req,
	input  logic      read_rsp_ack,
	output rsp_line_t read_rsp_line,
	output logic      write_rsp_req,
	input  logic      write_rsp_ack,
	output rsp_line_t write_rsp_line
);

	// Entry 0 serves reads and entry 1 writes, as in cmd_class_t
	logic      push  [2];
	logic      pop   [2];
	logic      full  [2];
	logic      empty [2];
	logic      req   [2];
	logic      ack   [2];
	rsp_line_t head  [2];
	rsp_line_t rsp_line;

	assign rsp_line.tag  = rsp.rsp_tag;
	assign rsp_line.code = rsp.rsp_code;
	assign rsp_line.addr = rsp.rsp_addr;

	assign ack[CLASS_READ]  = read_rsp_ack;
	assign ack[CLASS_WRITE] = write_rsp_ack;

	assign read_rsp_req   = req[CLASS_READ];
	assign write_rsp_req  = req[CLASS_WRITE];
	assign read_rsp_line  = head[CLASS_READ];
	assign write_rsp_line = head[CLASS_WRITE];

	for (genvar c = 0; c < 2; c++) begin : g_class
		assign push[c] = rsp.rsp_valid && (rsp.rsp_class == cmd_class_t'(c));
		// Requester has taken the line
		assign pop[c]  = req[c] && ack[c];

		cmd_queue #(
			.PAYLOAD_T(rsp_line_t),
			.DEPTH    (RSP_QUEUE_DEPTH)
		) i_rsp_queue (
			.clock    (clock),
			.rstn     (rstn),
			.push     (push[c]),
			.push_data(rsp_line),
			.pop      (pop[c]),
			.pop_data (head[c]),
			.full     (full[c]),
			.empty    (empty[c])
		);

		// Four-phase sender, next req only after ack has dropped
		always_ff @(posedge clock or negedge rstn) begin
			if (!rstn) begin
				req[c] <= 1'b0;
			end else if (req[c] && ack[c]) begin
				req[c] <= 1'b0;
			end else if (!req[c] && !ack[c] && !empty[c]) begin
				req[c] <= 1'b1;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstn)
		rsp.rsp_valid |-> !full[rsp.rsp_class]);

endmodule

//--- logic/afu_command_control.sv
`timescale 1ns/1ps

module afu_command_control import afu_pkg::*; (
	input  logic                clock,
	input  logic                rstn,
	input  logic                read_req,
	output logic                read_ack,
	input  logic [ADDR_W-1:0]   read_addr,
	input  logic                write_req,
	output logic                write_ack,
	input  logic [ADDR_W-1:0]   write_addr,
	output logic                host_cmd_valid,
	output cmd_class_t          host_cmd_class,
	output logic [TAG_W-1:0]    host_cmd_tag,
	output logic [ADDR_W-1:0]   host_cmd_addr,
	input  logic [CREDIT_W-1:0] room,
	input  logic                enabled,
	input  logic                host_rsp_valid,
	input  logic [TAG_W-1:0]    host_rsp_tag,
	input  rsp_code_t           host_rsp_code,
	output logic                read_rsp_req,
	input  logic                read_rsp_ack,
	output rsp_line_t           read_rsp_line,
	output logic                write_rsp_req,
	input  logic                write_rsp_ack,
	output rsp_line_t           write_rsp_line
);

	logic      read_push;
	logic      write_push;
	logic      read_full;
	logic      write_full;
	logic      read_pop;
	logic      write_pop;
	logic      read_empty;
	logic      write_empty;
	cmd_line_t read_push_line;
	cmd_line_t write_push_line;
	cmd_line_t read_line;
	cmd_line_t write_line;

	issue_if iss_bus ();
	rsp_if   rsp_bus ();

	//////////////////////////////////////////////////
	// Command intake and class queues
	//////////////////////////////////////////////////

	cmd_intake #(.CMD_CLASS(CLASS_READ)) i_read_intake (
		.clock(clock), .rstn(rstn), .req(read_req), .ack(read_ack), .addr(read_addr),
		.full(read_full), .push(read_push), .push_line(read_push_line)
	);

	cmd_intake #(.CMD_CLASS(CLASS_WRITE)) i_write_intake (
		.clock(clock), .rstn(rstn), .req(write_req), .ack(write_ack), .addr(write_addr),
		.full(write_full), .push(write_push), .push_line(write_push_line)
	);

	cmd_queue #(.PAYLOAD_T(cmd_line_t), .DEPTH(CMD_QUEUE_DEPTH)) i_read_queue (
		.clock(clock), .rstn(rstn), .push(read_push), .push_data(read_push_line),
		.pop(read_pop), .pop_data(read_line), .full(read_full), .empty(read_empty)
	);

	cmd_queue #(.PAYLOAD_T(cmd_line_t), .DEPTH(CMD_QUEUE_DEPTH)) i_write_queue (
		.clock(clock), .rstn(rstn), .push(write_push), .push_data(write_push_line),
		.pop(write_pop), .pop_data(write_line), .full(write_full), .empty(write_empty)
	);

	//////////////////////////////////////////////////
	// Issue, credits and tags
	//////////////////////////////////////////////////

	issue_fsm i_issue_fsm (
		.clock(clock), .rstn(rstn), .enabled(enabled),
		.read_empty(read_empty), .write_empty(write_empty),
		.read_line(read_line), .write_line(write_line),
		.read_pop(read_pop), .write_pop(write_pop), .iss(iss_bus.fsm),
		.host_cmd_valid(host_cmd_valid), .host_cmd_class(host_cmd_class),
		.host_cmd_tag(host_cmd_tag), .host_cmd_addr(host_cmd_addr)
	);

	credit_counter i_credit_counter (
		.clock(clock), .rstn(rstn), .enabled(enabled), .room(room),
		.rsp_valid(host_rsp_valid), .cred(iss_bus.credits)
	);

	tag_table i_tag_table (
		.clock(clock), .rstn(rstn), .iss(iss_bus.tags), .host_rsp_valid(host_rsp_valid),
		.host_rsp_tag(host_rsp_tag), .host_rsp_code(host_rsp_code), .rsp(rsp_bus.tags)
	);

	response_router i_response_router (
		.clock(clock), .rstn(rstn), .rsp(rsp_bus.router),
		.read_rsp_req(read_rsp_req), .read_rsp_ack(read_rsp_ack),
		.read_rsp_line(read_rsp_line), .write_rsp_req(write_rsp_req),
		.write_rsp_ack(write_rsp_ack), .write_rsp_line(write_rsp_line)
	);

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter real PERIOD_NS    = 8.0,
	parameter int  RESET_CYCLES = 10
) (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2.0) clock = ~clock;
	end

	// Reset drops just after a rising edge
	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		rstn = 1'b1;
	end

endmodule

//--- sim/tb_afu_command_control.sv
`timescale 1ns/1ps

module tb_afu_command_control import afu_pkg::*; ();

	localparam int NUM_CMDS    = 18;
	localparam int TIMEOUT     = 1000;
	localparam int ISSUED      = 0;
	localparam int ANSWERED    = 1;
	localparam int WRITES_BACK = 2;
	localparam int ALL_BACK    = 3;

	logic                clock;
	logic                rstn;
	logic                read_req;
	logic                read_ack;
	logic [ADDR_W-1:0]   read_addr;
	logic                write_req;
	logic                write_ack;
	logic [ADDR_W-1:0]   write_addr;
	logic                host_cmd_valid;
	cmd_class_t          host_cmd_class;
	logic [TAG_W-1:0]    host_cmd_tag;
	logic [ADDR_W-1:0]   host_cmd_addr;
	logic [CREDIT_W-1:0] room;
	logic                enabled;
	logic                host_rsp_valid;
	logic [TAG_W-1:0]    host_rsp_tag;
	rsp_code_t           host_rsp_code;
	logic                read_rsp_req;
	logic                read_rsp_ack;
	rsp_line_t           read_rsp_line;
	logic                write_rsp_req;
	logic                write_rsp_ack;
	rsp_line_t           write_rsp_line;

	// Three words per command in the file
	logic [31:0]       file_words [0:3*NUM_CMDS-1];
	int                cmd_class  [NUM_CMDS];
	logic [ADDR_W-1:0] cmd_addr   [NUM_CMDS];
	int                cmd_code   [NUM_CMDS];
	int                cmd_tag    [NUM_CMDS];

	// Scoreboard with one expected list per class
	int     exp_cmd [2][NUM_CMDS];
	int     exp_rsp [2][NUM_CMDS];
	int     cmd_wr [2];
	int     cmd_rd [2];
	int     rsp_wr [2];
	int     rsp_rd [2];
	int     n_returned [2];
	int     issued_class [NUM_CMDS];
	int     n_issued;
	int     n_answered;
	int     rsp_allowed;
	int     rsp_pick;
	int     gap;
	int     cycle;
	bit     busy    [NUM_TAGS];
	bit     pending [NUM_TAGS];
	int     due     [NUM_TAGS];
	int     tag_idx [NUM_TAGS];
	bit     free_valid;
	int     free_tag;
	bit     read_hold;
	integer seed;
	string  test_name;

	tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(10)) i_clock_gen (
		.clock(clock), .rstn(rstn)
	);

	afu_command_control i_afu_command_control (
		.clock(clock), .rstn(rstn), .read_req(read_req), .read_ack(read_ack),
		.read_addr(read_addr), .write_req(write_req), .write_ack(write_ack),
		.write_addr(write_addr), .host_cmd_valid(host_cmd_valid),
		.host_cmd_class(host_cmd_class), .host_cmd_tag(host_cmd_tag),
		.host_cmd_addr(host_cmd_addr), .room(room), .enabled(enabled),
		.host_rsp_valid(host_rsp_valid), .host_rsp_tag(host_rsp_tag),
		.host_rsp_code(host_rsp_code), .read_rsp_req(read_rsp_req),
		.read_rsp_ack(read_rsp_ack), .read_rsp_line(read_rsp_line),
		.write_rsp_req(write_rsp_req), .write_rsp_ack(write_rsp_ack),
		.write_rsp_line(write_rsp_line)
	);

	task automatic value_error(input string what, input longint expected, input longint actual);
		$display("Error in %s, %s: expected %0h, actual %0h", test_name, what, expected, actual);
		$display("Verification failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic fail_with(input string msg);
		$display("Failure in %s: %s", test_name, msg);
		$display("Verification failed");
		$fatal(1, "Stopped at the first error");
	endtask

	function automatic int lowest_free();
		int t;
		int low;
		low = -1;
		for (t = NUM_TAGS - 1; t >= 0; t--) begin
			if (!busy[t]) begin
				low = t;
			end
		end
		return low;
	endfunction

	function automatic int count_class(input int c, input int upto);
		int i;
		int n;
		n = 0;
		for (i = 0; i < upto; i++) begin
			if (cmd_class[i] == c) begin
				n++;
			end
		end
		return n;
	endfunction

	function automatic int progress(input int which);
		case (which)
			ISSUED:      return n_issued;
			ANSWERED:    return n_answered;
			WRITES_BACK: return n_returned[CLASS_WRITE];
			default:     return n_returned[CLASS_READ] + n_returned[CLASS_WRITE];
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Host model and issue checks
	//////////////////////////////////////////////////

	task automatic check_issue();
		int c;
		int t;
		int idx;
		c = int'(host_cmd_class);
		t = int'(host_cmd_tag);
		assert (!busy[t]) else value_error("busy state of issued tag", 0, 1);
		assert (t == lowest_free()) else value_error("issued tag", lowest_free(), t);
		assert (cmd_rd[c] < cmd_wr[c]) else fail_with("a command issued that was never sent");
		idx = exp_cmd[c][cmd_rd[c]];
		cmd_rd[c]++;
		assert (host_cmd_addr == cmd_addr[idx])
			else value_error("issued address", cmd_addr[idx], host_cmd_addr);
		issued_class[n_issued] = c;
		n_issued++;
		busy[t]      = 1'b1;
		pending[t]   = 1'b1;
		tag_idx[t]   = idx;
		cmd_tag[idx] = t;
		due[t]       = cycle + 2 + ($unsigned($random(seed)) % 10);
	endtask

	// Answer the lowest due tag, then pause so the return queues drain
	task automatic pick_response();
		int t;
		int c;
		rsp_pick = -1;
		if (gap > 0) begin
			gap--;
		end else if (n_answered < rsp_allowed) begin
			for (t = 0; t < NUM_TAGS; t++) begin
				if (rsp_pick < 0 && pending[t] && due[t] <= cycle) begin
					rsp_pick = t;
				end
			end
			if (rsp_pick >= 0) begin
				c = cmd_class[tag_idx[rsp_pick]];
				pending[rsp_pick] = 1'b0;
				exp_rsp[c][rsp_wr[c]] = tag_idx[rsp_pick];
				rsp_wr[c]++;
				n_answered++;
				gap = 3;
			end
		end
	endtask

	always @(posedge clock) begin
		if (rstn) begin
			if (host_cmd_valid) begin
				check_issue();
			end
			// Tag table frees a tag one edge after the host answers
			if (free_valid) begin
				busy[free_tag] = 1'b0;
			end
			free_valid = host_rsp_valid;
			free_tag   = int'(host_rsp_tag);
			pick_response();
		end
		cycle++;
		#1;
		if (rsp_pick >= 0) begin
			host_rsp_valid = 1'b1;
			host_rsp_tag   = TAG_W'(rsp_pick);
			host_rsp_code  = rsp_code_t'(cmd_code[tag_idx[rsp_pick]]);
		end else begin
			host_rsp_valid = 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Requesters on the return ports
	//////////////////////////////////////////////////

	task automatic check_return(input int c, input rsp_line_t line);
		int idx;
		assert (rsp_rd[c] < rsp_wr[c]) else fail_with("a response returned on the wrong port");
		idx = exp_rsp[c][rsp_rd[c]];
		rsp_rd[c]++;
		assert (line.tag == cmd_tag[idx]) else value_error("returned tag", cmd_tag[idx], line.tag);
		assert (int'(line.code) == cmd_code[idx])
			else value_error("returned code", cmd_code[idx], line.code);
		assert (line.addr == cmd_addr[idx])
			else value_error("returned address", cmd_addr[idx], line.addr);
		n_returned[c]++;
	endtask

	always @(posedge clock) begin
		bit read_next;
		bit write_next;
		read_next  = read_rsp_ack;
		write_next = write_rsp_ack;
		if (read_rsp_req === 1'b1 && !read_rsp_ack && !read_hold) begin
			check_return(CLASS_READ, read_rsp_line);
			read_next = 1'b1;
		end else if (read_rsp_req === 1'b0 && read_rsp_ack) begin
			read_next = 1'b0;
		end
		if (write_rsp_req === 1'b1 && !write_rsp_ack) begin
			check_return(CLASS_WRITE, write_rsp_line);
			write_next = 1'b1;
		end else if (write_rsp_req === 1'b0 && write_rsp_ack) begin
			write_next = 1'b0;
		end
		#1;
		read_rsp_ack  = read_next;
		write_rsp_ack = write_next;
	end

	//////////////////////////////////////////////////
	// Command sources
	//////////////////////////////////////////////////

	task automatic wait_ack(input int c, input bit level);
		int t;
		bit ack;
		t = 0;
		do begin
			@(posedge clock);
			ack = (c == CLASS_READ) ? read_ack : write_ack;
			t++;
		end while (ack != level && t < TIMEOUT);
		assert (ack == level) else fail_with("timed out on a command handshake");
		#1;
	endtask

	task automatic send_cmd(input int idx);
		int c;
		c = cmd_class[idx];
		exp_cmd[c][cmd_wr[c]] = idx;
		cmd_wr[c]++;
		if (c == CLASS_READ) begin
			read_addr = cmd_addr[idx];
			read_req  = 1'b1;
		end else begin
			write_addr = cmd_addr[idx];
			write_req  = 1'b1;
		end
		wait_ack(c, 1'b1);
		if (c == CLASS_READ) begin
			read_req = 1'b0;
		end else begin
			write_req = 1'b0;
		end
		wait_ack(c, 1'b0);
	endtask

	task automatic send_class(input int c, input int first, input int last);
		int i;
		for (i = first; i < last; i++) begin
			if (cmd_class[i] == c) begin
				send_cmd(i);
			end
		end
	endtask

	task automatic wait_progress(input int which, input int target, input string what);
		int t;
		t = 0;
		while (progress(which) < target && t < TIMEOUT) begin
			@(posedge clock);
			#1;
			t++;
		end
		assert (progress(which) >= target) else fail_with({"timed out waiting for ", what});
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			#1;
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int i;
		read_req       = 1'b0;
		read_addr      = '0;
		write_req      = 1'b0;
		write_addr     = '0;
		room           = '0;
		enabled        = 1'b0;
		host_rsp_valid = 1'b0;
		host_rsp_tag   = '0;
		host_rsp_code  = RSP_DONE;
		read_rsp_ack   = 1'b0;
		write_rsp_ack  = 1'b0;
		read_hold      = 1'b0;
		rsp_allowed    = 0;
		rsp_pick       = -1;
		seed           = 94;
		test_name      = "setup";

		$readmemh("sim/cmd_input.dat", file_words);
		assert (!$isunknown(file_words[3*NUM_CMDS-1]))
			else fail_with("the command file could not be read");
		for (i = 0; i < NUM_CMDS; i++) begin
			cmd_class[i] = int'(file_words[3*i][0]);
			cmd_addr[i]  = file_words[3*i+1];
			cmd_code[i]  = int'(file_words[3*i+2][1:0]);
		end

		i = 0;
		while (rstn !== 1'b1 && i < 50) begin
			@(posedge clock);
			i++;
		end
		assert (rstn === 1'b1) else fail_with("reset was never released");
		@(posedge clock);
		#1;
		assert ({host_cmd_valid, read_ack, write_ack, read_rsp_req, write_rsp_req} == 5'b0)
			else value_error("outputs after reset", 0,
				{host_cmd_valid, read_ack, write_ack, read_rsp_req, write_rsp_req});

		// Three reads and three writes wait, then three credits are spent
		test_name = "round_robin_credits";
		room = 4'd3;
		for (i = 0; i < 6; i++) begin
			send_cmd(i);
		end
		enabled = 1'b1;
		wait_progress(ISSUED, 3, "the first three issues");
		idle(24);
		assert (n_issued == 3) else value_error("issues without credit", 3, n_issued);
		for (i = 1; i <= 3; i++) begin
			rsp_allowed = i;
			wait_progress(ISSUED, 3 + i, "an issue after a returned credit");
			idle(24);
			assert (n_issued == 3 + i) else value_error("issues per credit", 3 + i, n_issued);
		end
		for (i = 0; i < 6; i++) begin
			assert (issued_class[i] == i % 2)
				else value_error("round robin class", i % 2, issued_class[i]);
		end
		rsp_allowed = 1000;
		wait_progress(ALL_BACK, 6, "the first six responses");

		// Both sources stream at once
		test_name = "intake_and_issue";
		enabled = 1'b0;
		room = 4'd8;
		idle(2);
		enabled = 1'b1;
		fork
			send_class(CLASS_READ, 6, 14);
			send_class(CLASS_WRITE, 6, 14);
		join
		wait_progress(ALL_BACK, 14, "the streamed responses");

		// Reads held at the requester while writes keep flowing
		test_name = "back_pressure";
		read_hold = 1'b1;
		for (i = 14; i < NUM_CMDS; i++) begin
			send_cmd(i);
		end
		wait_progress(ANSWERED, NUM_CMDS, "all host responses");
		wait_progress(WRITES_BACK, count_class(CLASS_WRITE, NUM_CMDS), "the write responses");
		idle(8);
		assert (read_rsp_req === 1'b1) else fail_with("no read response waits for its ack");
		read_hold = 1'b0;
		wait_progress(ALL_BACK, NUM_CMDS, "the held read responses");

		$display("Verification passed");
		$finish;
	end

endmodule

//--- sim/cmd_input.dat
// Columns: class (0 read, 1 write), address, host response code (0 done, 1 failed, 2 paged)
// First six for round robin and credits, next eight streamed, last four under back-pressure
0 00001000 0
1 00002000 0
0 00001040 1
1 00002040 0
1 00002080 2
0 00001080 0
0 000010c0 0
0 00001100 2
1 000020c0 0
0 00001140 0
1 00002100 1
1 00002140 0
0 00001180 0
1 00002180 0
0 000011c0 0
1 000021c0 2
0 00001200 1
1 00002200 0

//--- tb.f
common/afu_pkg.sv
common/issue_if.sv
common/rsp_if.sv
logic/cmd_intake.sv
logic/cmd_queue.sv
issue/issue_fsm.sv
issue/credit_counter.sv
logic/tag_table.sv
logic/response_router.sv
logic/afu_command_control.sv
sim/tb_clock_gen.sv
sim/tb_afu_command_control.sv
